//--- source/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// --------------------------------------------------
	// screen geometry
	// --------------------------------------------------
	localparam int screen_width  = 16;
	localparam int screen_height = 8;
	localparam int screen_hoffs  = 40;  // panel ram column offset
	localparam int screen_voffs  = 53;  // panel ram row offset
	localparam int pixel_count   = screen_width * screen_height;
	localparam int hctr_bits     = 4;
	localparam int vctr_bits     = 3;
	localparam int addr_bits     = 7;   // pixel memory address

	// pixel and serial format
	localparam int pixel_bits  = 16;
	localparam int serial_bits = 8;
	localparam int red_bits    = 5;
	localparam int green_bits  = 6;
	localparam int blue_bits   = 5;
	localparam int serial_div  = 2;     // clk cycles per sclk half period
	localparam int div_bits    = $clog2(serial_div);
	localparam int half_bits   = $clog2(2 * serial_bits);  // sclk half periods per word

	// waits in clk cycles, sim sized
	localparam int wait_reset       = 20;
	localparam int wait_after_reset = 40;
	localparam int wait_update      = 30;
	localparam int wait_bits        = $clog2(wait_after_reset + 1);  // longest wait

	// --------------------------------------------------
	// panel init sequence
	// --------------------------------------------------
	localparam int init_bytes = 17;
	localparam int init_bits  = $clog2(init_bytes);
	localparam logic [15:0] x_start = 16'(screen_hoffs);
	localparam logic [15:0] x_end   = 16'(screen_hoffs + screen_width - 1);
	localparam logic [15:0] y_start = 16'(screen_voffs);
	localparam logic [15:0] y_end   = 16'(screen_voffs + screen_height - 1);

	localparam logic [0:init_bytes-1][serial_bits-1:0] init_data = {
		8'h11, 8'h21, 8'h29,  // sleep out, inversion on, display on
		8'h2a, x_start[15:8], x_start[7:0], x_end[15:8], x_end[7:0],  // column window
		8'h2b, y_start[15:8], y_start[7:0], y_end[15:8], y_end[7:0],  // row window
		8'h36, 8'ha0,         // memory access mode
		8'h3a, 8'h55          // 16 bit pixels
	};
	localparam logic [0:init_bytes-1] init_cmd = 17'b000_01111_01111_01_01;  // 0 = command
	localparam logic [serial_bits-1:0] cmd_ram_write = 8'h2c;

	// host register map
	localparam int wb_addr_bits         = 8;
	localparam int ctrl_addr            = 128;
	localparam int ctrl_testpattern_bit = 0;
	localparam int ctrl_update_bit      = 1;

endpackage

`default_nettype wire

//--- source/serial_tx.sv
`default_nettype none

module serial_tx import lcd_pkg::*; (
	input  logic                   in_clk,
	input  logic                   in_rst,
	input  logic [serial_bits-1:0] tx_data,
	input  logic                   tx_enable,
	output logic                   sdo,
	output logic                   sclk,
	output logic                   tx_next_word,
	output logic                   tx_ready
);

	logic                   busy;       // word in flight
	logic [serial_bits-1:0] shift_reg;
	logic [div_bits-1:0]    div_ctr;    // clk cycles within half period
	logic [half_bits-1:0]   half_ctr;   // sclk half periods within word
	logic                   div_wrap;
	logic                   last_half;

	assign div_wrap  = div_ctr == div_bits'(serial_div - 1);
	assign last_half = half_ctr == half_bits'(2 * serial_bits - 1);

	// --------------------------------------------------
	// clock divider and sclk
	// --------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			busy     <= 1'b0;
			sclk     <= 1'b1;  // idles high
			div_ctr  <= '0;
			half_ctr <= '0;
		end else if (!busy) begin
			div_ctr  <= '0;
			half_ctr <= '0;
			if (tx_enable) begin
				busy <= 1'b1;
				sclk <= 1'b0;  // first falling edge, msb already out
			end
		end else begin
			div_ctr <= div_wrap ? '0 : div_ctr + 1'b1;
			if (div_wrap) begin
				half_ctr <= half_ctr + 1'b1;  // wraps to 0 after last half
				if (!half_ctr[0])
					sclk <= 1'b1;             // rising, panel samples
				else if (!last_half)
					sclk <= 1'b0;             // falling, next bit
				else if (tx_enable)
					sclk <= 1'b0;             // back to back word, clock keeps running
				else
					busy <= 1'b0;             // done, sclk stays high
			end
		end
	end

	// shift register, msb first
	always_ff @(posedge in_clk) begin
		if (!busy || (div_wrap && last_half))
			shift_reg <= tx_data;
		else if (div_wrap && half_ctr[0])
			shift_reg <= shift_reg << 1;  // data moves on falling edge
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	assign sdo          = busy & shift_reg[serial_bits-1];  // low when idle
	assign tx_ready     = !busy;
	assign tx_next_word = busy && (half_ctr[half_bits-1:1] == '1);  // last bit on the line

endmodule

`default_nettype wire

//--- source/testpattern.sv
`default_nettype none

module testpattern import lcd_pkg::*; (
	input  logic [hctr_bits-1:0]  hpix,
	input  logic [vctr_bits-1:0]  vpix,
	output logic [pixel_bits-1:0] pattern
);

	logic [1:0]            bar;     // 0 red, 1 green, 2 blue, 3 white
	logic                  bottom;  // lower half at half intensity
	logic [red_bits-1:0]   red;
	logic [green_bits-1:0] green;
	logic [blue_bits-1:0]  blue;

	assign bar    = hpix[hctr_bits-1 -: 2];  // four equal bars across
	assign bottom = int'(vpix) >= screen_height / 2;

	always_comb begin
		red   = (bar == 2'd0 || bar == 2'd3) ? '1 : '0;
		green = (bar == 2'd1 || bar == 2'd3) ? '1 : '0;
		blue  = (bar == 2'd2 || bar == 2'd3) ? '1 : '0;

		// halve each channel
		if (bottom) begin
			red   = red >> 1;
			green = green >> 1;
			blue  = blue >> 1;
		end
	end

	assign pattern = {red, green, blue};  // rgb565

endmodule

`default_nettype wire

//--- source/frame_ram.sv
`default_nettype none

module frame_ram import lcd_pkg::*; (
	input  logic                    in_clk,
	input  logic                    in_rst,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [wb_addr_bits-1:0] wb_adr,
	input  logic [pixel_bits-1:0]   wb_dat_w,
	input  logic [hctr_bits-1:0]    hpix,
	input  logic [vctr_bits-1:0]    vpix,
	output logic                    wb_ack,
	output logic [pixel_bits-1:0]   wb_dat_r,
	output logic [pixel_bits-1:0]   pixel,
	output logic                    testpattern,
	output logic                    update
);

	logic [pixel_bits-1:0] mem [pixel_count];  // raster order frame
	logic [pixel_bits-1:0] ctrl;               // control register
	logic                  req;                // new transfer this cycle
	logic                  pix_sel;
	logic                  ctrl_sel;
	logic [addr_bits-1:0]  rd_addr;            // controller side

	// --------------------------------------------------
	// wishbone decode
	// --------------------------------------------------
	assign req      = wb_cyc && wb_stb && !wb_ack;  // one ack per strobe
	assign pix_sel  = wb_adr < wb_addr_bits'(pixel_count);
	assign ctrl_sel = wb_adr == wb_addr_bits'(ctrl_addr);
	assign rd_addr  = addr_bits'(int'(vpix) * screen_width + int'(hpix));

	// ack and control register
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			wb_ack <= 1'b0;
			ctrl   <= '0;   // pattern off, no updates
		end else begin
			wb_ack <= req;  // exactly one cycle after strobe
			if (req && wb_we && ctrl_sel)
				ctrl <= wb_dat_w;
		end
	end

	// --------------------------------------------------
	// pixel memory, host and controller ports
	// --------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (req && wb_we && pix_sel)
			mem[wb_adr[addr_bits-1:0]] <= wb_dat_w;

		if (req) begin
			if (pix_sel)
				wb_dat_r <= mem[wb_adr[addr_bits-1:0]];
			else if (ctrl_sel)
				wb_dat_r <= ctrl;
			else
				wb_dat_r <= '0;  // unmapped reads as zero
		end

		pixel <= mem[rd_addr];  // one cycle after coordinates
	end

	assign testpattern = ctrl[ctrl_testpattern_bit];
	assign update      = ctrl[ctrl_update_bit];

endmodule

`default_nettype wire

//--- source/video_serial.sv
`default_nettype none

module video_serial import lcd_pkg::*; (
	input  logic                   in_clk,
	input  logic                   in_rst,
	input  logic [pixel_bits-1:0]  pixel,
	input  logic [pixel_bits-1:0]  pattern,
	input  logic                   testpattern,
	input  logic                   update,
	input  logic                   tx_next_word,
	input  logic                   tx_ready,
	output logic [hctr_bits-1:0]   hpix,
	output logic [vctr_bits-1:0]   vpix,
	output logic [serial_bits-1:0] tx_data,
	output logic                   tx_enable,
	output logic                   lcd_rst,
	output logic                   lcd_dc
);

	// --------------------------------------------------
	// states
	// --------------------------------------------------
	typedef enum logic [3:0] {
		st_reset,
		st_after_reset,
		st_write_init,
		st_next_init,
		st_wait_update,
		st_start_write,   // 0x2c command
		st_start_next,
		st_write_hi,
		st_next_hi,
		st_write_lo,
		st_next_pixel,
		st_end_frame
	} state_t;

	state_t                state;
	state_t                next_state;
	logic [init_bits-1:0]  init_ctr;
	logic [init_bits-1:0]  next_init_ctr;
	logic [hctr_bits-1:0]  next_hpix;
	logic [vctr_bits-1:0]  next_vpix;
	logic [wait_bits-1:0]  wait_ctr;    // shared by all waits
	logic [wait_bits-1:0]  wait_max;
	logic                  wait_done;
	logic                  last_next_word;
	logic                  byte_done;   // rising edge of next_word
	logic [pixel_bits-1:0] source;      // pixel word being sent
	logic                  last_col;
	logic                  last_row;

	assign byte_done = tx_next_word && !last_next_word;
	assign wait_done = wait_ctr >= wait_max;
	assign source    = testpattern ? pattern : pixel;
	assign last_col  = hpix == hctr_bits'(screen_width - 1);
	assign last_row  = vpix == vctr_bits'(screen_height - 1);

	// wait length per state
	always_comb begin
		case (state)
			st_reset:       wait_max = wait_bits'(wait_reset);
			st_after_reset: wait_max = wait_bits'(wait_after_reset);
			st_next_init:   wait_max = wait_bits'(wait_after_reset);  // used after sleep out only
			st_wait_update: wait_max = wait_bits'(wait_update);
			default:        wait_max = '0;
		endcase
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state          <= st_reset;
			init_ctr       <= '0;
			hpix           <= '0;
			vpix           <= '0;
			wait_ctr       <= '0;
			last_next_word <= 1'b0;
		end else begin
			state          <= next_state;
			init_ctr       <= next_init_ctr;
			hpix           <= next_hpix;
			vpix           <= next_vpix;
			last_next_word <= tx_next_word;

			// restart on every state change, saturate at max
			if (next_state != state)
				wait_ctr <= '0;
			else if (!wait_done)
				wait_ctr <= wait_ctr + 1'b1;
		end
	end

	// --------------------------------------------------
	// next state and outputs
	// --------------------------------------------------
	always_comb begin
		next_state    = state;
		next_init_ctr = init_ctr;
		next_hpix     = hpix;
		next_vpix     = vpix;
		tx_enable     = 1'b0;
		tx_data       = '0;
		lcd_rst       = 1'b0;
		lcd_dc        = 1'b0;

		case (state)
			st_reset: begin
				lcd_rst = 1'b1;  // panel held in reset
				if (wait_done)
					next_state = st_after_reset;
			end

			st_after_reset: begin
				if (wait_done)
					next_state = st_write_init;
			end

			// init sequence
			st_write_init: begin
				tx_enable = 1'b1;
				tx_data   = init_data[init_ctr];
				lcd_dc    = init_cmd[init_ctr];
				if (byte_done)
					next_state = st_next_init;
			end

			st_next_init: begin
				lcd_dc = init_cmd[init_ctr];  // hold dc through last bit
				if (tx_ready) begin
					if (init_ctr == '0) begin
						// panel needs time after sleep out
						if (wait_done) begin
							next_init_ctr = init_ctr + 1'b1;
							next_state    = st_write_init;
						end
					end else if (init_ctr == init_bits'(init_bytes - 1)) begin
						next_init_ctr = '0;
						next_state    = st_wait_update;
					end else begin
						next_init_ctr = init_ctr + 1'b1;
						next_state    = st_write_init;
					end
				end
			end

			// idle gap between frames
			st_wait_update: begin
				if (wait_done && update)
					next_state = st_start_write;
			end

			st_start_write: begin
				tx_enable = 1'b1;
				tx_data   = cmd_ram_write;
				if (byte_done)
					next_state = st_start_next;
			end

			st_start_next: begin
				if (tx_ready)
					next_state = st_write_hi;
			end

			// pixel bytes, high first
			st_write_hi: begin
				tx_enable = 1'b1;
				lcd_dc    = 1'b1;
				tx_data   = source[pixel_bits-1 -: serial_bits];
				if (byte_done)
					next_state = st_next_hi;
			end

			st_next_hi: begin
				lcd_dc = 1'b1;
				if (tx_ready)
					next_state = st_write_lo;
			end

			st_write_lo: begin
				tx_enable = 1'b1;
				lcd_dc    = 1'b1;
				tx_data   = source[serial_bits-1:0];
				if (byte_done) begin
					// step counters early so the ram read settles
					next_hpix = last_col ? '0 : hpix + 1'b1;
					if (last_col)
						next_vpix = last_row ? '0 : vpix + 1'b1;
					next_state = (last_col && last_row) ? st_end_frame : st_next_pixel;
				end
			end

			st_next_pixel: begin
				lcd_dc = 1'b1;
				if (tx_ready)
					next_state = st_write_hi;
			end

			st_end_frame: begin
				lcd_dc = 1'b1;
				if (tx_ready)
					next_state = st_wait_update;  // frame done
			end

			default: next_state = st_reset;
		endcase
	end

endmodule

`default_nettype wire

//--- source/lcd_top.sv
`default_nettype none

module lcd_top import lcd_pkg::*; (
	input  logic                    in_clk,
	input  logic                    in_rst,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [wb_addr_bits-1:0] wb_adr,
	input  logic [pixel_bits-1:0]   wb_dat_w,
	output logic                    wb_ack,
	output logic [pixel_bits-1:0]   wb_dat_r,
	output logic                    lcd_rst,
	output logic                    lcd_cs,
	output logic                    lcd_dc,
	output logic                    lcd_sclk,
	output logic                    lcd_sdo
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	logic [pixel_bits-1:0]  pixel;        // from frame memory
	logic [pixel_bits-1:0]  pattern;      // colour bars
	logic [hctr_bits-1:0]   hpix;
	logic [vctr_bits-1:0]   vpix;
	logic                   testpattern;  // control bits
	logic                   update;
	logic [serial_bits-1:0] tx_data;
	logic                   tx_enable;
	logic                   tx_next_word;
	logic                   tx_ready;

	frame_ram i_frame_ram (
		.in_clk      (in_clk),
		.in_rst      (in_rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.hpix        (hpix),
		.vpix        (vpix),
		.wb_ack      (wb_ack),
		.wb_dat_r    (wb_dat_r),
		.pixel       (pixel),
		.testpattern (testpattern),
		.update      (update)
	);

	testpattern i_testpattern (
		.hpix    (hpix),
		.vpix    (vpix),
		.pattern (pattern)
	);

	video_serial i_video_serial (
		.in_clk       (in_clk),
		.in_rst       (in_rst),
		.pixel        (pixel),
		.pattern      (pattern),
		.testpattern  (testpattern),
		.update       (update),
		.tx_next_word (tx_next_word),
		.tx_ready     (tx_ready),
		.hpix         (hpix),
		.vpix         (vpix),
		.tx_data      (tx_data),
		.tx_enable    (tx_enable),
		.lcd_rst      (lcd_rst),
		.lcd_dc       (lcd_dc)
	);

	serial_tx i_serial_tx (
		.in_clk       (in_clk),
		.in_rst       (in_rst),
		.tx_data      (tx_data),
		.tx_enable    (tx_enable),
		.sdo          (lcd_sdo),
		.sclk         (lcd_sclk),
		.tx_next_word (tx_next_word),
		.tx_ready     (tx_ready)
	);

	assign lcd_cs = tx_ready;  // active low, selected while a byte is shifting

endmodule

`default_nettype wire

//--- sim/lcd_props.sv
`default_nettype none

module lcd_props import lcd_pkg::*; (
	input logic                   in_clk,
	input logic                   in_rst,
	input logic                   lcd_rst,
	input logic                   lcd_dc,
	input logic                   tx_enable,
	input logic                   tx_ready,
	input logic                   tx_next_word,
	input logic [serial_bits-1:0] tx_data,
	input logic [hctr_bits-1:0]   hpix,
	input logic [vctr_bits-1:0]   vpix
);

	int error_count = 0;  // failed assertions so far

	// --------------------------------------------------
	// controller to shifter link
	// --------------------------------------------------

	// chip select only once the panel is out of reset
	assert property (@(posedge in_clk) disable iff (in_rst)
		$fell(tx_ready) |-> !$past(lcd_rst))
	else begin
		$error("shifter started while the panel reset was still asserted");
		error_count++;
	end

	assert property (@(posedge in_clk) disable iff (in_rst)
		tx_enable && $past(tx_enable) |-> $stable(tx_data) && $stable(lcd_dc))
	else begin
		$error("byte or dc changed while the shifter enable was high");
		error_count++;
	end

	// raster walk, column steps by one
	assert property (@(posedge in_clk) disable iff (in_rst)
		$changed(hpix) |-> hpix == $past(hpix) + 1'b1)
	else begin
		$error("column counter skipped or went backwards");
		error_count++;
	end

	assert property (@(posedge in_clk) disable iff (in_rst)
		$changed(vpix) |-> hpix == '0 && $past(hpix) == hctr_bits'(screen_width - 1))
	else begin
		$error("row counter moved away from the end of a line");
		error_count++;
	end

	assert property (@(posedge in_clk) disable iff (in_rst)
		$rose(tx_next_word) |=> !tx_enable)  // controller moves on at last bit
	else begin
		$error("shifter enable still high after the last bit started");
		error_count++;
	end

endmodule

bind video_serial lcd_props i_props (
	.in_clk       (in_clk),
	.in_rst       (in_rst),
	.lcd_rst      (lcd_rst),
	.lcd_dc       (lcd_dc),
	.tx_enable    (tx_enable),
	.tx_ready     (tx_ready),
	.tx_next_word (tx_next_word),
	.tx_data      (tx_data),
	.hpix         (hpix),
	.vpix         (vpix)
);

`default_nettype wire

//--- sim/tb_lcd_top.sv
`default_nettype none

module tb_lcd_top import lcd_pkg::*; ();

	localparam int clk_period   = 100;
	localparam int drive_delay  = 10;   // after rising edge
	localparam int reset_cycles = 16;
	localparam int byte_cycles  = 2 * serial_bits * serial_div + 8;  // shift plus handshake
	localparam int frame_bytes  = 1 + 2 * pixel_count;
	localparam int frame_cycles = frame_bytes * byte_cycles;
	localparam int init_cycles  = reset_cycles + wait_reset + 2 * wait_after_reset
		+ init_bytes * byte_cycles;
	localparam int watchdog_cycles = 4 * frame_cycles * 2 + init_cycles;
	localparam logic cs_idle = 1'b1;  // active low, deselected while idle

	logic                    in_clk;
	logic                    in_rst;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [wb_addr_bits-1:0] wb_adr;
	logic [pixel_bits-1:0]   wb_dat_w;
	logic                    wb_ack;
	logic [pixel_bits-1:0]   wb_dat_r;
	logic                    lcd_rst;
	logic                    lcd_cs;
	logic                    lcd_dc;
	logic                    lcd_sclk;
	logic                    lcd_sdo;

	logic [15:0]            lfsr_state = 16'd97;
	logic [pixel_bits-1:0]  pixels [pixel_count];       // host copy of the frame
	logic [pixel_bits-1:0]  frame_words [pixel_count];  // expected for current test
	logic [serial_bits:0]   rx_q [$];                   // {dc, byte} from the panel
	logic [serial_bits:0]   init_q [$];
	logic [serial_bits-1:0] rx_shift = '0;
	int                     rx_bits = 0;
	logic                   sclk_prev = 1'b1;
	string                  current_test;
	int                     test_errors;
	int                     tests_passed = 0;
	int                     tests_failed = 0;

	lcd_top i_dut (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_ack   (wb_ack),
		.wb_dat_r (wb_dat_r),
		.lcd_rst  (lcd_rst),
		.lcd_cs   (lcd_cs),
		.lcd_dc   (lcd_dc),
		.lcd_sclk (lcd_sclk),
		.lcd_sdo  (lcd_sdo)
	);

	initial begin
		in_clk = 1'b0;
		forever #(clk_period / 2) in_clk = ~in_clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge in_clk);
		$display("watchdog expired after %0d cycles in test %s", watchdog_cycles, current_test);
		$display("TEST FAIL");
		$finish;
	end

	// --------------------------------------------------
	// panel model, bits taken on rising sclk
	// --------------------------------------------------
	always @(negedge in_clk) begin
		if (in_rst) begin
			rx_bits   = 0;
			sclk_prev = 1'b1;
		end else begin
			if (lcd_sclk && !sclk_prev && lcd_cs != cs_idle) begin
				rx_shift = {rx_shift[serial_bits-2:0], lcd_sdo};  // msb first
				rx_bits++;
				if (rx_bits == serial_bits) begin
					rx_q.push_back({lcd_dc, rx_shift});
					rx_bits = 0;
				end
			end
			sclk_prev = lcd_sclk;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value      = {value[14:0], lfsr_state[0]};  // one step per bit
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("Error in %s, %s: expected %0h, actual %0h", current_test, what,
				expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors  = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s passed", current_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", current_test, test_errors);
		end
	endtask

	// --------------------------------------------------
	// wishbone master, one idle cycle between transfers
	// --------------------------------------------------
	task automatic wb_transfer(input logic we, input logic [wb_addr_bits-1:0] adr,
		input logic [pixel_bits-1:0] dat_w, output logic [pixel_bits-1:0] dat_r);
		int cycles;
		@(posedge in_clk);
		#drive_delay;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat_w;
		cycles   = 0;
		do begin
			@(posedge in_clk);
			#drive_delay;
			cycles++;
		end while (!wb_ack && cycles < 8);
		check_value("ack delay", 32'd1, 32'(cycles));
		dat_r  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [wb_addr_bits-1:0] adr, input logic [pixel_bits-1:0] dat);
		logic [pixel_bits-1:0] unused_r;
		wb_transfer(1'b1, adr, dat, unused_r);
	endtask

	task automatic wb_read(input logic [wb_addr_bits-1:0] adr, output logic [pixel_bits-1:0] dat);
		wb_transfer(1'b0, adr, '0, dat);
	endtask

	task automatic wait_bytes(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (rx_q.size() < count && cycles < limit) begin
			@(negedge in_clk);
			cycles++;
		end
		assert (rx_q.size() >= count) else begin
			$display("%s: only %0d of %0d panel bytes arrived in %0d cycles", current_test,
				rx_q.size(), count, limit);
			test_errors++;
		end
	endtask

	// expected init bytes, rebuilt from the panel commands
	task automatic push_cmd(input logic [7:0] b);
		init_q.push_back({1'b0, b});
	endtask

	task automatic push_word(input int w);
		init_q.push_back({1'b1, 8'(w >> 8)});  // high byte first
		init_q.push_back({1'b1, 8'(w)});
	endtask

	task automatic build_init();
		init_q.delete();
		push_cmd(8'h11);  // sleep out
		push_cmd(8'h21);
		push_cmd(8'h29);
		push_cmd(8'h2a);
		push_word(screen_hoffs);
		push_word(screen_hoffs + screen_width - 1);
		push_cmd(8'h2b);
		push_word(screen_voffs);
		push_word(screen_voffs + screen_height - 1);
		push_cmd(8'h36);
		init_q.push_back({1'b1, 8'ha0});
		push_cmd(8'h3a);
		init_q.push_back({1'b1, 8'h55});  // rgb565
	endtask

	// four bars red green blue white, lower half at half intensity
	function automatic logic [pixel_bits-1:0] bar_colour(input int x, input int y);
		int bar;
		int r;
		int g;
		int b;
		bar = x / (screen_width / 4);
		r   = (bar == 0 || bar == 3) ? (1 << red_bits) - 1 : 0;
		g   = (bar == 1 || bar == 3) ? (1 << green_bits) - 1 : 0;
		b   = (bar == 2 || bar == 3) ? (1 << blue_bits) - 1 : 0;
		if (y >= screen_height / 2) begin
			r = r / 2;
			g = g / 2;
			b = b / 2;
		end
		return pixel_bits'((r << (green_bits + blue_bits)) | (g << blue_bits) | b);
	endfunction

	task automatic check_frame();
		check_value("frame length", 32'(frame_bytes), 32'(rx_q.size()));
		if (rx_q.size() >= frame_bytes) begin
			check_value("ram write command", 32'h02c, 32'(rx_q[0]));
			for (int i = 0; i < pixel_count; i++) begin
				check_value($sformatf("pixel %0d high", i), 32'({1'b1, frame_words[i][15:8]}),
					32'(rx_q[1 + 2 * i]));
				check_value($sformatf("pixel %0d low", i), 32'({1'b1, frame_words[i][7:0]}),
					32'(rx_q[2 + 2 * i]));
			end
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	initial begin
		logic [pixel_bits-1:0] word;
		logic [pixel_bits-1:0] ctrl_word;
		logic                  done;
		int                    count;
		int                    prop_errors;
		in_rst   = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;

		start_test("reset");
		repeat (reset_cycles) begin
			@(negedge in_clk);
			check_value("lcd_rst in reset", 32'd1, 32'(lcd_rst));
			check_value("lcd_cs in reset", 32'(cs_idle), 32'(lcd_cs));
			check_value("wb_ack in reset", 32'd0, 32'(wb_ack));
		end
		@(posedge in_clk);
		#drive_delay;
		in_rst = 1'b0;
		count  = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge in_clk);
			if (lcd_rst && count <= wait_reset + 1) begin
				count++;
				check_value("lcd_cs after reset", 32'(cs_idle), 32'(lcd_cs));
				check_value("wb_ack before strobe", 32'd0, 32'(wb_ack));
			end else
				done = 1'b1;
		end
		check_value("panel reset cycles", 32'(wait_reset + 1), 32'(count));
		finish_test();

		// runs while the controller sends its init bytes
		start_test("wishbone");
		for (int a = 0; a < pixel_count; a++) begin
			random_bits(pixel_bits, word);
			pixels[a] = word;
			wb_write(wb_addr_bits'(a), word);
		end
		random_bits(pixel_bits, ctrl_word);
		ctrl_word[ctrl_update_bit] = 1'b0;  // no frames yet
		wb_write(wb_addr_bits'(ctrl_addr), ctrl_word);
		for (int a = 0; a < pixel_count; a++) begin
			wb_read(wb_addr_bits'(a), word);
			check_value($sformatf("pixel %0d", a), 32'(pixels[a]), 32'(word));
		end
		wb_read(wb_addr_bits'(ctrl_addr), word);
		check_value("control register", 32'(ctrl_word), 32'(word));
		wb_read(wb_addr_bits'(ctrl_addr + 1), word);
		check_value("unmapped address", 32'd0, 32'(word));
		finish_test();

		start_test("init sequence");
		build_init();
		wait_bytes(init_bytes, init_cycles);
		if (rx_q.size() >= init_bytes) begin
			for (int i = 0; i < init_bytes; i++)
				check_value($sformatf("init byte %0d", i), 32'(init_q[i]), 32'(rx_q[i]));
		end
		finish_test();

		start_test("frame from memory");
		rx_q.delete();
		for (int i = 0; i < pixel_count; i++)
			frame_words[i] = pixels[i];
		wb_write(wb_addr_bits'(ctrl_addr), pixel_bits'(1 << ctrl_update_bit));
		wait_bytes(frame_bytes, 2 * frame_cycles);
		// switch source inside the gap before the next frame
		wb_write(wb_addr_bits'(ctrl_addr),
			pixel_bits'((1 << ctrl_update_bit) | (1 << ctrl_testpattern_bit)));
		check_frame();
		finish_test();

		start_test("test pattern");
		rx_q.delete();
		for (int i = 0; i < pixel_count; i++)
			frame_words[i] = bar_colour(i % screen_width, i / screen_width);
		wait_bytes(frame_bytes, 2 * frame_cycles);
		wb_write(wb_addr_bits'(ctrl_addr), '0);  // updates off
		check_frame();
		finish_test();

		start_test("update off");
		rx_q.delete();
		repeat (3 * frame_cycles) @(negedge in_clk);
		check_value("bytes while idle", 32'd0, 32'(rx_q.size()));
		finish_test();

		prop_errors = i_dut.i_video_serial.i_props.error_count;
		$display("tests passed %0d, failed %0d, property failures %0d", tests_passed,
			tests_failed, prop_errors);
		if (tests_failed == 0 && prop_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
source/lcd_pkg.sv
source/serial_tx.sv
source/testpattern.sv
source/frame_ram.sv
source/video_serial.sv
source/lcd_top.sv
sim/lcd_props.sv
sim/tb_lcd_top.sv

//--- Makefile
# Verilator build and run for the LCD controller testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_lcd_top
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
